// File: logic/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;          // PC, instruction and bus data
    typedef logic [5:0]  imem_idx_t;      // Instruction memory word index
    typedef logic [7:0]  axil_addr_t;     // Debug port byte address

    localparam int    IMEM_DEPTH = 64;    // Words of instruction memory
    localparam word_t PC_STEP    = 32'd4; // One instruction in bytes

    // Debug register map
    localparam axil_addr_t REG_CTRL      = 8'h00;  // Bit 0 is run
    localparam axil_addr_t REG_STEP      = 8'h04;  // Any write issues one step
    localparam axil_addr_t REG_IMEM_ADDR = 8'h08;  // Load pointer
    localparam axil_addr_t REG_IMEM_DATA = 8'h0C;  // Load data, pointer auto-increments
    localparam axil_addr_t REG_PC        = 8'h10;  // Read only
    localparam axil_addr_t REG_CYCLE     = 8'h14;  // Read only
    localparam axil_addr_t REG_INSTR     = 8'h18;  // Read only

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Host to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        word_t      wdata;
        logic [3:0] wstrb;                // Only full words are written
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // Slave to host
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        word_t      rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

// File: logic/program_counter.sv
module program_counter (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_step,        // Step grant from debug port
    input  logic             i_hazard,      // Stall request
    input  logic             i_jump,        // Select jump target
    input  fetch_pkg::word_t i_jump_addr,   // Jump target
    output fetch_pkg::word_t o_pc
);
    import fetch_pkg::*;

    word_t pc_q;
    word_t pc_seq;                          // Sequential address
    word_t pc_next;                         // Selected next address
    logic  advance;

    // Adder for the fall-through path
    assign pc_seq = pc_q + PC_STEP;

    // Next-PC select, jump has priority
    always_comb begin
        if (i_jump) begin
            pc_next = i_jump_addr;
        end else begin
            pc_next = pc_seq;
        end
    end

    // A hazard freezes the PC even on a granted step
    assign advance = i_step && !i_hazard;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q <= '0;
        end else if (advance) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule

// File: logic/instruction_memory.sv
module instruction_memory (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  fetch_pkg::word_t     i_fetch_addr,  // Byte address from the PC
    input  logic                 i_wr_en,       // Debug load strobe
    input  fetch_pkg::imem_idx_t i_wr_idx,      // Debug load word index
    input  fetch_pkg::word_t     i_wr_data,     // Debug load word
    output fetch_pkg::word_t     o_instr
);
    import fetch_pkg::*;

    localparam int IDX_MSB = $bits(imem_idx_t) + 1;  // Top address bit of the index

    word_t     mem [IMEM_DEPTH];
    imem_idx_t fetch_idx;

    // Drop byte offset, upper bits wrap around the array
    assign fetch_idx = i_fetch_addr[IDX_MSB:2];

    // Zero-latency fetch
    assign o_instr = mem[fetch_idx];

    // Memory starts out all zero so an unloaded program fetches NOPs
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

// File: logic/debug_axil_slave.sv
module debug_axil_slave (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  fetch_pkg::axil_req_t i_axil,
    output fetch_pkg::axil_rsp_t o_axil,
    input  fetch_pkg::word_t     i_pc,            // Readback only
    input  fetch_pkg::word_t     i_instr,         // Readback only
    output logic                 o_step,
    output logic                 o_imem_wr_en,
    output fetch_pkg::imem_idx_t o_imem_wr_idx,
    output fetch_pkg::word_t     o_imem_wr_data,
    output fetch_pkg::word_t     o_cycle_count
);
    import fetch_pkg::*;

    localparam int IDX_MSB = $bits(imem_idx_t) + 1;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    logic       wr_hs;                    // Address and data accepted together
    logic       rd_hs;
    logic       wr_legal;
    logic [1:0] bresp_q;
    word_t      rdata_q;
    logic [1:0] rresp_q;
    word_t      rd_data;
    logic [1:0] rd_resp;
    logic       run_q;
    logic       step_pulse_q;             // One-shot from REG_STEP
    word_t      imem_ptr_q;               // Load pointer as a byte address
    word_t      cycle_q;

    // Handshakes only fire in the idle state of each channel
    assign wr_hs = (wr_state == WR_IDLE) && i_axil.awvalid && i_axil.wvalid;
    assign rd_hs = (rd_state == RD_IDLE) && i_axil.arvalid;

    always_comb begin
        case (i_axil.awaddr)
            REG_CTRL, REG_STEP, REG_IMEM_ADDR, REG_IMEM_DATA: begin
                wr_legal = 1'b1;
            end
            default: begin
                wr_legal = 1'b0;          // Read-only or unmapped
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_hs) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (i_axil.bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_hs) begin
            bresp_q <= wr_legal ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Illegal writes fall through to default and change nothing
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            run_q        <= 1'b0;
            step_pulse_q <= 1'b0;
            imem_ptr_q   <= '0;
        end else begin
            step_pulse_q <= wr_hs && (i_axil.awaddr == REG_STEP);
            if (wr_hs) begin
                case (i_axil.awaddr)
                    REG_CTRL: begin
                        run_q <= i_axil.wdata[0];
                    end
                    REG_IMEM_ADDR: begin
                        imem_ptr_q <= i_axil.wdata;
                    end
                    REG_IMEM_DATA: begin
                        imem_ptr_q <= imem_ptr_q + PC_STEP;  // Next word
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Memory load lands on the same edge as the handshake
    assign o_imem_wr_en   = wr_hs && (i_axil.awaddr == REG_IMEM_DATA);
    assign o_imem_wr_idx  = imem_ptr_q[IDX_MSB:2];
    assign o_imem_wr_data = i_axil.wdata;

    assign o_step = run_q || step_pulse_q;  // Free run or single step

    // Counts granted steps including stalled ones
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cycle_q <= '0;
        end else if (o_step) begin
            cycle_q <= cycle_q + 32'd1;
        end
    end

    assign o_cycle_count = cycle_q;

    // Write-only registers read as zero
    always_comb begin
        rd_resp = RESP_OKAY;
        case (i_axil.araddr)
            REG_CTRL:                rd_data = word_t'(run_q);
            REG_STEP, REG_IMEM_DATA: rd_data = '0;
            REG_IMEM_ADDR:           rd_data = imem_ptr_q;
            REG_PC:                  rd_data = i_pc;
            REG_CYCLE:               rd_data = cycle_q;
            REG_INSTR:               rd_data = i_instr;
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_hs) begin
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (i_axil.rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // Sampled at the address handshake
    always_ff @(posedge i_clk) begin
        if (rd_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        o_axil.awready = wr_hs;
        o_axil.wready  = wr_hs;
        o_axil.bresp   = bresp_q;
        o_axil.bvalid  = (wr_state == WR_RESP);
        o_axil.arready = (rd_state == RD_IDLE);
        o_axil.rdata   = rdata_q;
        o_axil.rresp   = rresp_q;
        o_axil.rvalid  = (rd_state == RD_DATA);
    end

endmodule

// File: logic/instruction_fetch.sv
module instruction_fetch (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // Debug port
    input  fetch_pkg::axil_req_t i_axil,
    output fetch_pkg::axil_rsp_t o_axil,

    // From later stages
    input  logic                 i_jump,
    input  fetch_pkg::word_t     i_jump_addr,
    input  logic                 i_hazard,

    output fetch_pkg::word_t     o_pc,
    output fetch_pkg::word_t     o_instr,        // Fetched instruction
    output fetch_pkg::word_t     o_cycle_count
);
    import fetch_pkg::*;

    logic      step;
    logic      imem_wr_en;
    imem_idx_t imem_wr_idx;
    word_t     imem_wr_data;
    word_t     pc;
    word_t     instr;

    program_counter u_pc (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_step      (step),               // From debug run or step
        .i_hazard    (i_hazard),
        .i_jump      (i_jump),
        .i_jump_addr (i_jump_addr),
        .o_pc        (pc)
    );

    instruction_memory u_imem (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_fetch_addr (pc),
        .i_wr_en      (imem_wr_en),        // Debug load path
        .i_wr_idx     (imem_wr_idx),
        .i_wr_data    (imem_wr_data),
        .o_instr      (instr)
    );

    debug_axil_slave u_debug (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_axil         (i_axil),
        .o_axil         (o_axil),
        .i_pc           (pc),              // Readback
        .i_instr        (instr),           // Readback
        .o_step         (step),
        .o_imem_wr_en   (imem_wr_en),
        .o_imem_wr_idx  (imem_wr_idx),
        .o_imem_wr_data (imem_wr_data),
        .o_cycle_count  (o_cycle_count)
    );

    assign o_pc    = pc;
    assign o_instr = instr;

endmodule

// File: verif/fetch_checker.sv
module fetch_checker (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  fetch_pkg::axil_req_t i_axil_req,
    input  fetch_pkg::axil_rsp_t i_axil_rsp,
    input  logic                 i_jump,
    input  fetch_pkg::word_t     i_jump_addr,
    input  logic                 i_hazard,
    input  fetch_pkg::word_t     i_pc,
    input  fetch_pkg::word_t     i_instr,
    input  fetch_pkg::word_t     i_cycle_count,
    output int                   o_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    word_t      shadow [IMEM_DEPTH];  // Reference instruction memory
    logic       run_m;
    logic       pend_m;               // Step from REG_STEP due at the next edge
    word_t      ptr_m;
    word_t      pc_m;
    word_t      cycle_m;
    word_t      exp_rdata;
    logic [1:0] exp_rresp;
    logic [1:0] exp_bresp;
    axil_req_t  req_s;                // Port values sampled mid-cycle
    axil_rsp_t  rsp_s;
    logic       jump_s;
    word_t      jump_addr_s;
    logic       hazard_s;
    int         errors = 0;

    function automatic word_t shadow_at(input word_t addr);
        return shadow[addr[7:2]];
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Model steps on the rising edge from the values sampled at the falling edge
    always @(posedge i_clk) begin : model_update
        logic step;
        if (i_reset) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                shadow[i] = '0;
            end
            run_m   = 1'b0;
            pend_m  = 1'b0;
            ptr_m   = '0;
            pc_m    = '0;
            cycle_m = '0;
        end else begin
            step = run_m || pend_m;
            if (req_s.arvalid && rsp_s.arready) begin  // Read address accepted at this edge
                exp_rresp = RESP_OKAY;
                case (req_s.araddr)
                    REG_CTRL:      exp_rdata = {31'd0, run_m};
                    REG_IMEM_ADDR: exp_rdata = ptr_m;
                    REG_PC:        exp_rdata = pc_m;
                    REG_CYCLE:     exp_rdata = cycle_m;
                    REG_INSTR:     exp_rdata = shadow_at(pc_m);
                    REG_STEP, REG_IMEM_DATA: exp_rdata = '0;
                    default: begin
                        exp_rdata = '0;
                        exp_rresp = RESP_SLVERR;
                    end
                endcase
            end
            if (step) begin
                cycle_m = cycle_m + 32'd1;              // Counts under hazard too
                if (!hazard_s) begin
                    pc_m = jump_s ? jump_addr_s : pc_m + 32'd4;
                end
            end
            pend_m = 1'b0;
            if (req_s.awvalid && req_s.wvalid && rsp_s.awready && rsp_s.wready) begin
                exp_bresp = RESP_OKAY;
                case (req_s.awaddr)
                    REG_CTRL:      run_m = req_s.wdata[0];
                    REG_STEP:      pend_m = 1'b1;
                    REG_IMEM_ADDR: ptr_m = req_s.wdata;
                    REG_IMEM_DATA: begin
                        shadow[ptr_m[7:2]] = req_s.wdata;
                        ptr_m = ptr_m + 32'd4;  // Auto-increment
                    end
                    default:       exp_bresp = RESP_SLVERR;  // Read-only or unmapped
                endcase
            end
        end
    end

    always @(negedge i_clk) begin : compare_outputs
        req_s       = i_axil_req;
        rsp_s       = i_axil_rsp;
        jump_s      = i_jump;
        jump_addr_s = i_jump_addr;
        hazard_s    = i_hazard;
        if (!i_reset) begin
            check_value("o_pc", pc_m, i_pc);
            check_value("o_instr", shadow_at(pc_m), i_instr);
            check_value("o_cycle_count", cycle_m, i_cycle_count);
            if (i_axil_rsp.bvalid && i_axil_req.bready) begin
                check_value("bresp", {30'd0, exp_bresp}, {30'd0, i_axil_rsp.bresp});
            end
            if (i_axil_rsp.rvalid && i_axil_req.rready) begin
                check_value("rdata", exp_rdata, i_axil_rsp.rdata);
                check_value("rresp", {30'd0, exp_rresp}, {30'd0, i_axil_rsp.rresp});
            end
        end
    end

    assign o_errors = errors;

endmodule

// File: verif/tb_instruction_fetch.sv
module tb_instruction_fetch;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_SET, OP_IDLE} op_t;

    typedef struct packed {
        op_t        op;
        axil_addr_t addr;
        word_t      data;       // Write data, or cycle count for idle
        logic       jump;
        word_t      jump_addr;
        logic       hazard;
        logic [1:0] resp;       // Expected bresp or rresp
    } entry_t;

    logic        clk;
    logic        reset;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic        jump;
    word_t       jump_addr;
    logic        hazard;
    word_t       pc;
    word_t       instr;
    word_t       cycle_count;
    int          chk_errors;
    int          tb_errors = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    logic [15:0] lfsr_q = 16'd11;
    entry_t      stim_q[$];

    instruction_fetch dut0 (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_axil        (req),
        .o_axil        (rsp),
        .i_jump        (jump),
        .i_jump_addr   (jump_addr),
        .i_hazard      (hazard),
        .o_pc          (pc),
        .o_instr       (instr),
        .o_cycle_count (cycle_count)
    );

    fetch_checker chk0 (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_axil_req    (req),
        .i_axil_rsp    (rsp),
        .i_jump        (jump),
        .i_jump_addr   (jump_addr),
        .i_hazard      (hazard),
        .i_pc          (pc),
        .i_instr       (instr),
        .i_cycle_count (cycle_count),
        .o_errors      (chk_errors)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic word_t take_bits(input int n);
        word_t bits;
        logic  fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic add_entry(input op_t op, input axil_addr_t addr, input word_t data,
                             input logic j, input word_t ja, input logic h,
                             input logic [1:0] resp);
        entry_t e;
        e = '{op, addr, data, j, ja, h, resp};
        stim_q.push_back(e);
    endtask

    task automatic build_stimulus();
        add_entry(OP_WRITE, REG_IMEM_ADDR, 32'h0, 0, 0, 0, RESP_OKAY);
        for (int i = 0; i < 16; i++) begin
            add_entry(OP_WRITE, REG_IMEM_DATA, take_bits(32), 0, 0, 0, RESP_OKAY);  // Random program
        end
        for (int i = 0; i < 16; i++) begin
            add_entry(OP_READ, REG_INSTR, 0, 0, 0, 0, RESP_OKAY);
            add_entry(OP_WRITE, REG_STEP, 32'h1, 0, 0, 0, RESP_OKAY);
        end
        add_entry(OP_READ, REG_PC, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, REG_CYCLE, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_WRITE, REG_CTRL, 32'h1, 0, 0, 0, RESP_OKAY);        // Free run
        add_entry(OP_IDLE, 0, 32'd5, 0, 0, 0, RESP_OKAY);
        add_entry(OP_SET, 0, 0, 1, 32'h0000_0020, 0, RESP_OKAY);         // One-cycle jump
        add_entry(OP_SET, 0, 0, 0, 32'h0, 0, RESP_OKAY);
        add_entry(OP_IDLE, 0, 32'd4, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, REG_INSTR, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_SET, 0, 0, 0, 32'h0, 1, RESP_OKAY);                 // Stall
        add_entry(OP_IDLE, 0, 32'd4, 0, 0, 0, RESP_OKAY);
        add_entry(OP_SET, 0, 0, 1, 32'h0000_0008, 1, RESP_OKAY);         // Hazard beats jump
        add_entry(OP_SET, 0, 0, 0, 32'h0, 0, RESP_OKAY);
        add_entry(OP_IDLE, 0, 32'd3, 0, 0, 0, RESP_OKAY);
        add_entry(OP_WRITE, REG_CTRL, 32'h0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, REG_CTRL, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, 8'h1C, 0, 0, 0, 0, RESP_SLVERR);              // Unmapped
        add_entry(OP_WRITE, REG_PC, 32'h0000_0100, 0, 0, 0, RESP_SLVERR);
        add_entry(OP_WRITE, 8'h40, 32'h0000_0001, 0, 0, 0, RESP_SLVERR);
        add_entry(OP_READ, REG_PC, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, REG_IMEM_ADDR, 0, 0, 0, 0, RESP_OKAY);
        add_entry(OP_READ, REG_CYCLE, 0, 0, 0, 0, RESP_OKAY);
    endtask

    task automatic wait_cycles(input word_t n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Address and data go out together and bready follows after a random delay
    task automatic axi_write(input axil_addr_t addr, input word_t data, input int delay,
                             output logic [1:0] resp);
        logic accepted;
        accepted    = 1'b0;
        req.awaddr  = addr;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = rsp.awready && rsp.wready;
            @(posedge clk);
            #1;
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        @(negedge clk);
        while (!rsp.bvalid) @(negedge clk);
        resp = rsp.bresp;
        wait_cycles(delay + 1);
        req.bready = 1'b1;
        wait_cycles(1);
        req.bready = 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, input int delay, output logic [1:0] resp);
        logic accepted;
        accepted    = 1'b0;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = rsp.arready;
            @(posedge clk);
            #1;
        end
        req.arvalid = 1'b0;
        @(negedge clk);
        while (!rsp.rvalid) @(negedge clk);
        resp = rsp.rresp;
        wait_cycles(delay + 1);
        req.rready = 1'b1;
        wait_cycles(1);
        req.rready = 1'b0;
    endtask

    task automatic check_resp(input string name, input int idx, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            tb_errors++;
            $display("FAIL t=%0t %s (entry %0d) expected %0d actual %0d",
                     $time, name, idx, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a handshake or the sequence never completed", cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        entry_t     e;
        logic [1:0] resp;
        reset     = 1'b1;
        req       = '0;
        jump      = 1'b0;
        jump_addr = '0;
        hazard    = 1'b0;
        build_stimulus();
        cycle_limit = stim_q.size() * 20 + 100;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (stim_q[k]) begin
            e = stim_q[k];
            case (e.op)
                OP_WRITE: begin
                    axi_write(e.addr, e.data, int'(take_bits(2)), resp);  // 0 to 3 cycles late
                    check_resp("bresp", k, e.resp, resp);
                end
                OP_READ: begin
                    axi_read(e.addr, int'(take_bits(2)), resp);
                    check_resp("rresp", k, e.resp, resp);
                end
                OP_SET: begin
                    jump      = e.jump;
                    jump_addr = e.jump_addr;
                    hazard    = e.hazard;
                    wait_cycles(1);
                end
                default: wait_cycles(e.data);
            endcase
        end
        wait_cycles(3);
        $display("Errors: %0d testbench, %0d checker", tb_errors, chk_errors);
        if (tb_errors == 0 && chk_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: instruction_fetch.f
logic/fetch_pkg.sv
logic/program_counter.sv
logic/instruction_memory.sv
logic/debug_axil_slave.sv
logic/instruction_fetch.sv
verif/fetch_checker.sv
verif/tb_instruction_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for the failure message
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_instruction_fetch -f instruction_fetch.f \
    -o tb_instruction_fetch > "$LOG" 2>&1 \
    && ./obj_dir/tb_instruction_fetch >> "$LOG" 2>&1 \
    || { echo "Build or run error, see $LOG"; exit 1; }

grep -q "Simulation failed" "$LOG" \
    && { echo "FAILED, see $LOG"; exit 1; } \
    || { echo "PASSED"; exit 0; }
